/* bench/cipherBench.sv */
// Cipher unit testbench
`timescale 1ns/100ps
`default_nettype none

module cipherBench;

    localparam int KeyLength   = 10;
    localparam int ClockPeriod = 40;
    localparam int DriveDelay  = 2;
    localparam int ResetCycles = 4;
    // Seven words per stimulus entry
    // Memory holds up to 73 entries
    localparam int EntryWords  = 7;
    localparam int MaxWords    = 512;

    // Entry kind sits in the first word
    localparam logic [79:0] KindKey     = 80'd1;
    localparam logic [79:0] KindRequest = 80'd2;

    logic                              clock;
    logic                              rstN;
    logic                              inValid;
    cipherPkg::cipherReqT              req;
    logic                              keyLoad;
    cipherPkg::letterT [KeyLength-1:0] keyIn;
    logic                              outValid;
    cipherPkg::cipherRespT             resp;

    logic [79:0]       stimMem [MaxWords];
    // Expected responses in request order
    cipherPkg::letterT expLetterQ [$];
    logic              expMissingQ [$];
    int                entryCount;
    int                cycleCount;
    int                cycleLimit;
    int                errorCount;
    int                checkCount;

    cipherTop #(
        .KeyLength(KeyLength)
    ) i_dut (
        .clock   (clock),
        .rstN    (rstN),
        .inValid (inValid),
        .req     (req),
        .keyLoad (keyLoad),
        .keyIn   (keyIn),
        .outValid(outValid),
        .resp    (resp)
    );

    always #(ClockPeriod / 2) clock = ~clock;

    task automatic checkLetter(input cipherPkg::letterT actual,
                               input cipherPkg::letterT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %0t: response letter 0x%02h, expected 0x%02h",
                     $time, actual, expected);
        end
    endtask

    task automatic checkKeyMissing(input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %0t: keyMissing %b, expected %b", $time, actual, expected);
        end
    endtask

    task automatic driveIdle();
        inValid = 1'b0;
        keyLoad = 1'b0;
    endtask

    // One stimulus entry for one clock cycle
    task automatic applyEntry(input int base);
        logic [79:0] kind;
        kind = stimMem[base];
        driveIdle();
        if (kind == KindKey) begin
            keyIn   = stimMem[base+1];
            keyLoad = 1'b1;
        end else begin
            req.letter      = cipherPkg::letterT'(stimMem[base+1]);
            req.mode        = cipherPkg::modeE'(stimMem[base+2][0]);
            req.op          = cipherPkg::opE'(stimMem[base+3][0]);
            req.caesarShift = cipherPkg::shiftT'(stimMem[base+4]);
            inValid         = 1'b1;
            expLetterQ.push_back(cipherPkg::letterT'(stimMem[base+5]));
            expMissingQ.push_back(stimMem[base+6][0]);
        end
    endtask

    // Response monitor on the falling edge
    always @(negedge clock) begin
        if (rstN && outValid) begin
            if (expLetterQ.size() == 0) begin
                errorCount++;
                $display("Response at %0t with no request outstanding", $time);
            end else begin
                checkLetter(resp.letter, expLetterQ.pop_front());
                checkKeyMissing(resp.keyMissing, expMissingQ.pop_front());
            end
        end
    end

    // Run limit
    always @(posedge clock) begin
        cycleCount++;
        if ((cycleLimit > 0) && (cycleCount > cycleLimit)) begin
            $display("Timeout after %0d cycles, %0d responses never arrived",
                     cycleCount, expLetterQ.size());
            $display("Checks %0d, errors %0d", checkCount, errorCount);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int gap;
        void'($urandom(32'hafae_44cf));
        clock      = 1'b0;
        rstN       = 1'b0;
        inValid    = 1'b0;
        keyLoad    = 1'b0;
        req        = '0;
        keyIn      = '0;
        cycleCount = 0;
        cycleLimit = 0;
        errorCount = 0;
        checkCount = 0;

        for (int i = 0; i < MaxWords; i++) begin
            stimMem[i] = '0;
        end
        $readmemh("bench/cipherStimulus.txt", stimMem);

        // Entries end at the first word that is no known kind
        entryCount = 0;
        while (((entryCount + 1) * EntryWords <= MaxWords) &&
               ((stimMem[entryCount * EntryWords] == KindKey) ||
                (stimMem[entryCount * EntryWords] == KindRequest))) begin
            entryCount++;
        end
        if (entryCount == 0) begin
            errorCount++;
            $display("No stimulus entries found in bench/cipherStimulus.txt");
        end
        cycleLimit = entryCount * 6 + 20;

        repeat (ResetCycles) @(posedge clock);
        #DriveDelay;
        rstN = 1'b1;

        for (int e = 0; e < entryCount; e++) begin
            // 0 to 3 idle cycles before each entry
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clock);
                #DriveDelay;
                driveIdle();
            end
            @(posedge clock);
            #DriveDelay;
            applyEntry(e * EntryWords);
        end
        @(posedge clock);
        #DriveDelay;
        driveIdle();

        // Wait for outstanding responses
        while (expLetterQ.size() != 0) begin
            @(posedge clock);
        end
        // Spare cycles catch stray responses
        repeat (2) @(posedge clock);

        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/cipherStimulus.txt */
// kind letter mode op caesarShift expLetter expKeyMissing   (kind 2 = request)
// kind key(first letter in low byte) 0 0 0 0 0             (kind 1 = key load)
// Vigenere before any key load
2 48 1 0 00 48 1
2 31 1 1 00 31 1
// Caesar encrypt, wrap and shifts of 26 and above
2 41 0 0 03 44 0
2 5A 0 0 01 41 0
2 58 0 0 05 43 0
2 4D 0 0 1A 4D 0
2 42 0 0 1F 47 0
2 51 0 0 1D 54 0
2 59 0 0 0D 4C 0
// Caesar decrypt
2 44 0 1 03 41 0
2 41 0 1 01 5A 0
2 43 0 1 05 58 0
2 47 0 1 1F 42 0
2 54 0 1 1D 51 0
2 4C 0 1 0D 59 0
2 4D 0 1 1B 4C 0
// Caesar non-letters
2 20 0 0 03 20 0
2 61 0 1 05 61 0
2 39 0 0 07 39 0
// Key CIPHERKEYZ
1 5A59454B524548504943 0 0 0 0 0
2 48 1 0 00 4A 0
2 45 1 0 00 4D 0
2 20 1 0 00 20 0
2 4C 1 0 00 41 0
2 78 1 0 00 78 0
2 4C 1 0 00 53 0
2 4F 1 0 00 53 0
2 57 1 1 00 46 0
2 41 1 1 00 51 0
2 5A 1 1 00 56 0
2 42 1 0 00 5A 0
2 43 1 0 00 42 0
// Key wraps to its first letter, caesarShift ignored
2 59 1 0 00 41 0
2 51 1 1 1F 49 0
2 45 0 0 02 47 0
2 41 1 0 00 50 0
// Reload restarts the key
1 5A59454B524548504943 0 0 0 0 0
2 4A 1 1 00 48 0
2 4D 1 1 00 45 0
// Key Z1aBAAAAAA, non-letter key bytes shift by 0
1 4141414141414261315A 0 0 0 0 0
2 42 1 0 00 41 0
2 4B 1 0 00 4B 0
2 4B 1 1 00 4B 0
2 37 1 1 00 37 0
2 41 1 1 00 5A 0

/* bench/cipher_checker.sv */
// Cipher unit port assertions
`timescale 1ns/100ps
`default_nettype none

module cipherChecker (
    input logic clock,
    input logic rstN,
    input logic inValid,
    input logic keyLoad,
    input logic outValid
);

    // Async reset holds the response strobe low
    outValidLowInReset: assert property (
        @(posedge clock) !rstN |-> !outValid
    ) else $error("outValid high while reset is asserted");

    // Fixed one cycle latency, no back-pressure
    outValidFollowsInValid: assert property (
        @(posedge clock) disable iff (!rstN) outValid == $past(inValid)
    ) else $error("outValid does not follow inValid by one cycle");

    // Key loads and requests use separate cycles
    keyLoadApartFromRequest: assert property (
        @(posedge clock) disable iff (!rstN) !(keyLoad && inValid)
    ) else $error("keyLoad and inValid high in the same cycle");

endmodule

bind cipherTop cipherChecker i_checker (
    .clock   (clock),
    .rstN    (rstN),
    .inValid (inValid),
    .keyLoad (keyLoad),
    .outValid(outValid)
);

`default_nettype wire

/* filelist.f */
hw/cipherPkg.sv
hw/letterDecoder.sv
hw/letterEncoder.sv
hw/rotateUnit.sv
hw/keyRing.sv
hw/cipherControl.sv
hw/cipherTop.sv
bench/cipher_checker.sv
bench/cipherBench.sv

/* hw/cipherControl.sv */
// Request handling and response register
`timescale 1ns/100ps
`default_nettype none

module cipherControl #(
    parameter int KeyLength = 10
) (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic                  inValid,
    input  cipherPkg::cipherReqT  req,
    input  logic                  keyLoad,
    input  logic                  isLetter,
    input  cipherPkg::shiftT      keyShift,
    input  cipherPkg::letterT     encoded,
    output cipherPkg::letterT     decodeLetter,
    output cipherPkg::shiftT      shift,
    output cipherPkg::opE         op,
    output logic                  keyStep,
    output logic                  outValid,
    output cipherPkg::cipherRespT resp
);

    cipherPkg::keyStateE keyState;
    logic                useKey;
    logic                keyMissing;

    // Datapath feed, straight from the request
    assign decodeLetter = req.letter;
    assign op           = req.op;

    assign useKey     = (req.mode == cipherPkg::modeVigenere);
    assign keyMissing = useKey && (keyState == cipherPkg::keyEmpty);

    // Shift source
    always_comb begin
        if (!useKey) begin
            shift = req.caesarShift;
        end else if (keyState == cipherPkg::keyReady) begin
            shift = keyShift;
        end else begin
            shift = '0;
        end
    end

    // Advance key on accepted letters only
    // single-letter key never moves
    assign keyStep = inValid && useKey && isLetter && !keyMissing && (KeyLength > 1);

    // Key state
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            keyState <= cipherPkg::keyEmpty;
        end else if (keyLoad) begin
            keyState <= cipherPkg::keyReady;
        end
    end

    // One cycle latency valid
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Response payload
    always_ff @(posedge clock) begin
        if (inValid) begin
            // Non-letters and keyless Vigenere pass through
            if (isLetter && !keyMissing) begin
                resp.letter <= encoded;
            end else begin
                resp.letter <= req.letter;
            end
            resp.keyMissing <= keyMissing;
        end
    end

endmodule

`default_nettype wire

/* hw/cipherPkg.sv */
// Cipher unit shared types
`default_nettype none

package cipherPkg;

    // Alphabet size and bounds
    localparam int AlphabetSize = 26;

    typedef logic [7:0] letterT;

    localparam letterT LetterA = "A";
    localparam letterT LetterZ = "Z";

    // One-hot letter, bit 0 is A
    typedef logic [AlphabetSize-1:0] oneHotT;

    // Rotation amount, up to 31 before reduction
    typedef logic [4:0] shiftT;

    typedef enum logic {
        modeCaesar,
        modeVigenere
    } modeE;

    typedef enum logic {
        opEncrypt,
        opDecrypt
    } opE;

    typedef enum logic {
        keyEmpty,
        keyReady
    } keyStateE;

    // One character request, 15 bits
    typedef struct packed {
        letterT letter;
        modeE   mode;
        opE     op;
        shiftT  caesarShift;
    } cipherReqT;

    // One character response, 9 bits
    typedef struct packed {
        letterT letter;
        logic   keyMissing;
    } cipherRespT;

endpackage

`default_nettype wire

/* hw/cipherTop.sv */
// Character cipher unit top level
`timescale 1ns/100ps
`default_nettype none

module cipherTop #(
    parameter int KeyLength = 10
) (
    input  logic                              clock,
    input  logic                              rstN,
    input  logic                              inValid,
    input  cipherPkg::cipherReqT              req,
    input  logic                              keyLoad,
    input  cipherPkg::letterT [KeyLength-1:0] keyIn,
    output logic                              outValid,
    output cipherPkg::cipherRespT             resp
);

    cipherPkg::letterT decodeLetter;
    cipherPkg::oneHotT position;
    logic              isLetter;
    cipherPkg::shiftT  shift;
    cipherPkg::opE     op;
    cipherPkg::oneHotT rotated;
    cipherPkg::letterT encoded;
    cipherPkg::shiftT  keyShift;
    logic              keyStep;

    cipherControl #(
        .KeyLength(KeyLength)
    ) i_control (
        .clock       (clock),
        .rstN        (rstN),
        .inValid     (inValid),
        .req         (req),
        .keyLoad     (keyLoad),
        .isLetter    (isLetter),
        .keyShift    (keyShift),
        .encoded     (encoded),
        .decodeLetter(decodeLetter),
        .shift       (shift),
        .op          (op),
        .keyStep     (keyStep),
        .outValid    (outValid),
        .resp        (resp)
    );

    // Combinational letter path
    letterDecoder i_decoder (
        .letter  (decodeLetter),
        .position(position),
        .isLetter(isLetter)
    );

    rotateUnit i_rotate (
        .position(position),
        .shift   (shift),
        .op      (op),
        .rotated (rotated)
    );

    letterEncoder i_encoder (
        .position(rotated),
        .letter  (encoded)
    );

    // Key loads directly from the top ports
    keyRing #(
        .KeyLength(KeyLength)
    ) i_keyRing (
        .clock   (clock),
        .rstN    (rstN),
        .keyLoad (keyLoad),
        .keyIn   (keyIn),
        .keyStep (keyStep),
        .keyShift(keyShift)
    );

endmodule

`default_nettype wire

/* hw/keyRing.sv */
// Vigenere key storage and stepping
`timescale 1ns/100ps
`default_nettype none

module keyRing #(
    parameter int KeyLength = 10
) (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic                               keyLoad,
    input  cipherPkg::letterT [KeyLength-1:0]  keyIn,
    input  logic                               keyStep,
    output cipherPkg::shiftT                   keyShift
);

    localparam int IndexWidth = (KeyLength > 1) ? $clog2(KeyLength) : 1;
    localparam logic [IndexWidth-1:0] LastIndex = IndexWidth'(KeyLength - 1);

    cipherPkg::letterT [KeyLength-1:0] keyStore;
    logic [IndexWidth-1:0]             keyIndex;
    cipherPkg::letterT                 currentLetter;

    // Key letters, first letter in slot 0
    always_ff @(posedge clock) begin
        if (keyLoad) begin
            keyStore <= keyIn;
        end
    end

    // Ring position
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            keyIndex <= '0;
        end else if (keyLoad) begin
            // New key restarts at its first letter
            keyIndex <= '0;
        end else if (keyStep) begin
            if (keyIndex == LastIndex) begin
                keyIndex <= '0;
            end else begin
                keyIndex <= keyIndex + 1'b1;
            end
        end
    end

    always_comb begin
        currentLetter = keyStore[keyIndex];
        // Alphabet index of the key letter, 0 for anything outside A-Z
        if ((currentLetter >= cipherPkg::LetterA) && (currentLetter <= cipherPkg::LetterZ)) begin
            keyShift = cipherPkg::shiftT'(currentLetter - cipherPkg::LetterA);
        end else begin
            keyShift = '0;
        end
    end

endmodule

`default_nettype wire

/* hw/letterDecoder.sv */
// ASCII to one-hot letter
`timescale 1ns/100ps
`default_nettype none

module letterDecoder (
    input  cipherPkg::letterT letter,
    output cipherPkg::oneHotT position,
    output logic              isLetter
);

    always_comb begin
        // Uppercase only, everything else is a non-letter
        isLetter = (letter >= cipherPkg::LetterA) && (letter <= cipherPkg::LetterZ);
        position = '0;
        // One bit per letter, A at bit 0
        for (int i = 0; i < cipherPkg::AlphabetSize; i++) begin
            if (letter == cipherPkg::letterT'(cipherPkg::LetterA + i)) begin
                position[i] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/letterEncoder.sv */
// One-hot letter to ASCII
`timescale 1ns/100ps
`default_nettype none

module letterEncoder (
    input  cipherPkg::oneHotT position,
    output cipherPkg::letterT letter
);

    always_comb begin
        case (position)
            26'h000_0001: letter = "A";
            26'h000_0002: letter = "B";
            26'h000_0004: letter = "C";
            26'h000_0008: letter = "D";
            26'h000_0010: letter = "E";
            26'h000_0020: letter = "F";
            26'h000_0040: letter = "G";
            26'h000_0080: letter = "H";
            26'h000_0100: letter = "I";
            26'h000_0200: letter = "J";
            26'h000_0400: letter = "K";
            26'h000_0800: letter = "L";
            26'h000_1000: letter = "M";
            26'h000_2000: letter = "N";
            26'h000_4000: letter = "O";
            26'h000_8000: letter = "P";
            26'h001_0000: letter = "Q";
            26'h002_0000: letter = "R";
            26'h004_0000: letter = "S";
            26'h008_0000: letter = "T";
            26'h010_0000: letter = "U";
            26'h020_0000: letter = "V";
            26'h040_0000: letter = "W";
            26'h080_0000: letter = "X";
            26'h100_0000: letter = "Y";
            26'h200_0000: letter = "Z";
            // Not one-hot, only seen for non-letters
            default:      letter = cipherPkg::LetterA;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rotateUnit.sv */
// Circular letter rotation
`timescale 1ns/100ps
`default_nettype none

module rotateUnit (
    input  cipherPkg::oneHotT position,
    input  cipherPkg::shiftT  shift,
    input  cipherPkg::opE     op,
    output cipherPkg::oneHotT rotated
);

    localparam int DoubleWidth = 2 * cipherPkg::AlphabetSize;

    cipherPkg::shiftT         reduced;
    logic [DoubleWidth-1:0] doubled;
    logic [DoubleWidth-1:0] leftShifted;
    logic [DoubleWidth-1:0] rightShifted;

    always_comb begin
        // Shift range 0..31, one subtraction brings it into 0..25
        if (shift >= cipherPkg::AlphabetSize) begin
            reduced = cipherPkg::shiftT'(shift - cipherPkg::AlphabetSize);
        end else begin
            reduced = shift;
        end

        // Two copies side by side so bits wrap around
        doubled      = {position, position};
        leftShifted  = doubled << reduced;
        rightShifted = doubled >> reduced;

        // Encrypt moves towards Z, decrypt towards A
        if (op == cipherPkg::opEncrypt) begin
            rotated = leftShifted[DoubleWidth-1:cipherPkg::AlphabetSize];
        end else begin
            rotated = rightShifted[cipherPkg::AlphabetSize-1:0];
        end
    end

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Compile and run the cipher unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cipherBench -f filelist.f -o cipherSim \
    && ./obj_dir/cipherSim | tee /dev/stderr | grep -x "No errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
